//--- design/gp_reg_file.sv
`include "sm83_regs_settings.svh"

module gp_reg_file (
	input  logic                 clk,
	input  logic                 arst_n,
	input  sm83_regs_pkg::uop_t  uop,
	input  sm83_regs_pkg::byte_t data_in,
	input  sm83_regs_pkg::byte_t alu_res,
	input  sm83_regs_pkg::addr_t idu_res,
	output sm83_regs_pkg::byte_t src_byte,
	output sm83_regs_pkg::byte_t a_out,
	output sm83_regs_pkg::byte_t ir,
	output sm83_regs_pkg::addr_t pair_val
);

	import sm83_regs_pkg::*;

	byte_t    regs [8];   // Indexed by register code, slot 6 stays zero
	byte_t    wr_byte;
	reg_idx_t hi_idx;     // B, D or H
	reg_idx_t lo_idx;     // C, E or L
	logic     pair_wb;

	// First register of a pair has the even code
	assign hi_idx = {uop.pair, 1'b0};
	assign lo_idx = {uop.pair, 1'b1};

	assign pair_wb = (uop.idu_wb == `SM83_WB_PAIR) && (uop.pair != `SM83_PAIR_SP);

	assign src_byte = regs[uop.src_idx];
	assign a_out    = regs[`SM83_REG_A];
	assign pair_val = {regs[hi_idx], regs[lo_idx]};  // Don't care for the SP code

	always_comb begin
		case (uop.dst_src)
			`SM83_DSRC_DATA: wr_byte = data_in;
			`SM83_DSRC_ALU:  wr_byte = alu_res;
			default:         wr_byte = src_byte;  // Register to register move
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
			ir <= '0;
		end else begin
			if (pair_wb) begin
				regs[hi_idx] <= idu_res[15:8];
				regs[lo_idx] <= idu_res[7:0];
			end
			// Issued after the pair write so the byte write wins a collision
			if (uop.dst_we && (uop.dst_idx != `SM83_REG_HLM)) begin
				regs[uop.dst_idx] <= wr_byte;
			end
			if (uop.ir_ld) begin
				ir <= data_in;   // Opcode fetch
			end
		end
	end

endmodule

//--- design/idu.sv
`include "sm83_regs_settings.svh"

module idu (
	input  sm83_regs_pkg::uop_t  uop,
	input  sm83_regs_pkg::addr_t pc,
	input  sm83_regs_pkg::addr_t pair_val,
	input  sm83_regs_pkg::addr_t sp,
	input  sm83_regs_pkg::addr_t wz,
	output sm83_regs_pkg::addr_t addr,
	output sm83_regs_pkg::addr_t idu_res
);

	import sm83_regs_pkg::*;

	addr_t pair_src;

	// SP is not in the general file
	assign pair_src = (uop.pair == `SM83_PAIR_SP) ? sp : pair_val;

	always_comb begin
		case (uop.asrc)
			`SM83_ASRC_PAIR: addr = pair_src;
			`SM83_ASRC_WZ:   addr = wz;
			default:         addr = pc;
		endcase
	end

	// Wraps at 16 bits in both directions
	always_comb begin
		case (uop.idu_op)
			`SM83_IDU_INC: idu_res = addr + 16'd1;
			`SM83_IDU_DEC: idu_res = addr - 16'd1;
			default:       idu_res = addr;   // Pass
		endcase
	end

endmodule

//--- design/pointer_regs.sv
`include "sm83_regs_settings.svh"

module pointer_regs (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 sync_res,
	input  sm83_regs_pkg::uop_t  uop,
	input  sm83_regs_pkg::addr_t idu_res,
	input  sm83_regs_pkg::addr_t wz,
	output sm83_regs_pkg::addr_t pc,
	output sm83_regs_pkg::addr_t sp
);

	import sm83_regs_pkg::*;

	addr_t pc_next;
	logic  pc_ld;
	logic  sp_ld;

	// Synchronous clear first, then jump, then IDU write-back
	always_comb begin
		pc_ld   = 1'b1;
		pc_next = idu_res;
		if (sync_res) begin
			pc_next = '0;
		end else if (uop.jump) begin
			pc_next = wz;
		end else if (uop.idu_wb != `SM83_WB_PC) begin
			pc_ld = 1'b0;
		end
	end

	// SP is written as its own target or as pair code 3
	assign sp_ld = (uop.idu_wb == `SM83_WB_SP) ||
		((uop.idu_wb == `SM83_WB_PAIR) && (uop.pair == `SM83_PAIR_SP));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
		end else if (pc_ld) begin
			pc <= pc_next;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sp <= '0;
		end else if (sp_ld) begin
			sp <= idu_res;
		end
	end

endmodule

//--- design/sm83_regs_pkg.sv
`include "sm83_regs_settings.svh"

package sm83_regs_pkg;

	typedef logic [`SM83_DATA_W-1:0]     byte_t;      // Data bus byte
	typedef logic [`SM83_ADDR_W-1:0]     addr_t;      // Address or register pair
	typedef logic [`SM83_REG_IDX_W-1:0]  reg_idx_t;   // Opcode register code
	typedef logic [`SM83_PAIR_IDX_W-1:0] pair_idx_t;  // Opcode pair code

	// One micro-op from the external decoder, valid for a single clock
	typedef struct packed {
		logic       ir_ld;     // Opcode fetch into IR
		logic       dst_we;
		reg_idx_t   dst_idx;
		logic [1:0] dst_src;   // DSRC_* codes
		reg_idx_t   src_idx;   // Byte read port
		logic       z_we;
		logic       w_we;
		logic [1:0] asrc;      // ASRC_* codes
		pair_idx_t  pair;
		logic [1:0] idu_op;    // IDU_* codes
		logic [1:0] idu_wb;    // WB_* codes
		logic       jump;      // PC <= WZ
		logic [2:0] out_src;   // OUT_* codes
	} uop_t;

endpackage

//--- design/sm83_regs_settings.svh
`ifndef SM83_REGS_SETTINGS_SVH
`define SM83_REGS_SETTINGS_SVH

`define SM83_DATA_W      8
`define SM83_ADDR_W      16
`define SM83_REG_IDX_W   3
`define SM83_PAIR_IDX_W  2

// Register codes as in the opcode r field
`define SM83_REG_B    3'd0
`define SM83_REG_C    3'd1
`define SM83_REG_D    3'd2
`define SM83_REG_E    3'd3
`define SM83_REG_H    3'd4
`define SM83_REG_L    3'd5
`define SM83_REG_HLM  3'd6   // (HL) memory operand, no register behind it
`define SM83_REG_A    3'd7

`define SM83_PAIR_BC  2'd0
`define SM83_PAIR_DE  2'd1
`define SM83_PAIR_HL  2'd2
`define SM83_PAIR_SP  2'd3

`define SM83_ASRC_PC    2'd0
`define SM83_ASRC_PAIR  2'd1
`define SM83_ASRC_WZ    2'd2

`define SM83_IDU_PASS  2'd0
`define SM83_IDU_INC   2'd1
`define SM83_IDU_DEC   2'd2

`define SM83_WB_NONE  2'd0
`define SM83_WB_PC    2'd1
`define SM83_WB_SP    2'd2
`define SM83_WB_PAIR  2'd3

`define SM83_DSRC_DATA  2'd0
`define SM83_DSRC_ALU   2'd1
`define SM83_DSRC_REG   2'd2

`define SM83_OUT_REG  3'd0
`define SM83_OUT_PCL  3'd1
`define SM83_OUT_PCH  3'd2
`define SM83_OUT_SPL  3'd3
`define SM83_OUT_SPH  3'd4

`endif

//--- design/sm83_regs_top.sv
`include "sm83_regs_settings.svh"

module sm83_regs_top (
	input  logic                 clk,
	input  logic                 arst_n,
	input  sm83_regs_pkg::uop_t  uop,
	input  sm83_regs_pkg::byte_t data_in,
	input  sm83_regs_pkg::byte_t alu_res,
	input  logic                 sync_res,
	output sm83_regs_pkg::addr_t addr,
	output sm83_regs_pkg::byte_t data_out,
	output sm83_regs_pkg::byte_t a_out,
	output sm83_regs_pkg::byte_t ir
);

	import sm83_regs_pkg::*;

	byte_t src_byte;
	addr_t pair_val;   // BC, DE or HL
	addr_t wz;
	addr_t pc;
	addr_t sp;
	addr_t idu_res;    // Back to PC, SP or a pair

	gp_reg_file gp_reg_file_inst (
		.clk      (clk),
		.arst_n   (arst_n),
		.uop      (uop),
		.data_in  (data_in),
		.alu_res  (alu_res),
		.idu_res  (idu_res),
		.src_byte (src_byte),
		.a_out    (a_out),
		.ir       (ir),
		.pair_val (pair_val)
	);

	wz_temp_regs wz_temp_regs_inst (
		.clk     (clk),
		.arst_n  (arst_n),
		.uop     (uop),
		.data_in (data_in),
		.wz      (wz)
	);

	pointer_regs pointer_regs_inst (
		.clk      (clk),
		.arst_n   (arst_n),
		.sync_res (sync_res),
		.uop      (uop),
		.idu_res  (idu_res),
		.wz       (wz),
		.pc       (pc),
		.sp       (sp)
	);

	idu idu_inst (
		.uop      (uop),
		.pc       (pc),
		.pair_val (pair_val),
		.sp       (sp),
		.wz       (wz),
		.addr     (addr),
		.idu_res  (idu_res)
	);

	// Pointer bytes go out for pushes and stores of SP
	always_comb begin
		case (uop.out_src)
			`SM83_OUT_PCL: data_out = pc[7:0];
			`SM83_OUT_PCH: data_out = pc[15:8];
			`SM83_OUT_SPL: data_out = sp[7:0];
			`SM83_OUT_SPH: data_out = sp[15:8];
			default:       data_out = src_byte;
		endcase
	end

endmodule

//--- design/wz_temp_regs.sv
module wz_temp_regs (
	input  logic                 clk,
	input  logic                 arst_n,
	input  sm83_regs_pkg::uop_t  uop,
	input  sm83_regs_pkg::byte_t data_in,
	output sm83_regs_pkg::addr_t wz
);

	import sm83_regs_pkg::*;

	byte_t w_q;   // High byte of an immediate
	byte_t z_q;   // Low byte, arrives first

	// Z and W load separately, so a 16-bit immediate takes two cycles
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			z_q <= '0;
			w_q <= '0;
		end else begin
			if (uop.z_we) begin
				z_q <= data_in;
			end
			if (uop.w_we) begin
				w_q <= data_in;
			end
		end
	end

	assign wz = {w_q, z_q};   // Jump target or indirect address

endmodule

//--- sm83_regs.f
+incdir+design
design/sm83_regs_pkg.sv
design/gp_reg_file.sv
design/wz_temp_regs.sv
design/pointer_regs.sv
design/idu.sv
design/sm83_regs_top.sv
testbench/sm83_regs_chk.sv
testbench/sm83_regs_tb.sv

//--- testbench/sm83_regs_chk.sv
`include "sm83_regs_settings.svh"

module sm83_regs_chk (
	input logic                 clk,
	input logic                 arst_n,
	input logic                 sync_res,
	input sm83_regs_pkg::uop_t  uop,
	input sm83_regs_pkg::addr_t addr,
	input sm83_regs_pkg::byte_t a_out,
	input sm83_regs_pkg::addr_t pc
);

	timeunit 1ns;
	timeprecision 100ps;

	import sm83_regs_pkg::*;

	logic a_write;   // Micro-op targets the accumulator
	int   assert_errs = 0;

	assign a_write = uop.dst_we && (uop.dst_idx == `SM83_REG_A);

	addr_known: assert property (@(posedge clk) disable iff (!arst_n) !$isunknown(addr))
		else begin
			assert_errs++;
			$error("addr carries unknown bits");
		end

	pc_cleared: assert property (@(posedge clk) disable iff (!arst_n) sync_res |=> (pc == '0))
		else begin
			assert_errs++;
			$error("pc is not zero in the cycle after sync_res");
		end

	// Pairs never cover A, so only a byte write may change it
	a_held: assert property (@(posedge clk) disable iff (!arst_n) !a_write |=> $stable(a_out))
		else begin
			assert_errs++;
			$error("a_out changed without a write to A");
		end

endmodule

//--- testbench/sm83_regs_tb.sv
`include "sm83_regs_settings.svh"

module sm83_regs_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import sm83_regs_pkg::*;

	localparam int NUM_UOPS   = 2000;
	localparam int CLK_PERIOD = 4;

	logic  clk;
	logic  arst_n;
	uop_t  uop;
	byte_t data_in;
	byte_t alu_res;
	logic  sync_res;
	addr_t addr;
	byte_t data_out;
	byte_t a_out;
	byte_t ir;

	byte_t m_regs [8];   // Reference registers by opcode code
	byte_t m_ir;
	byte_t m_w;
	byte_t m_z;
	addr_t m_pc;
	addr_t m_sp;

	integer seed = 32'hcca1;
	int     addr_errs;
	int     data_errs;
	int     a_errs;
	int     ir_errs;
	int     chk_errs;

	sm83_regs_top sm83_regs_top_inst (
		.clk      (clk),
		.arst_n   (arst_n),
		.uop      (uop),
		.data_in  (data_in),
		.alu_res  (alu_res),
		.sync_res (sync_res),
		.addr     (addr),
		.data_out (data_out),
		.a_out    (a_out),
		.ir       (ir)
	);

	bind sm83_regs_top sm83_regs_chk sm83_regs_chk_inst (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// First register of a pair holds the high byte
	function automatic reg_idx_t hi_code(pair_idx_t p);
		case (p)
			`SM83_PAIR_BC: return `SM83_REG_B;
			`SM83_PAIR_DE: return `SM83_REG_D;
			default:       return `SM83_REG_H;
		endcase
	endfunction

	function automatic reg_idx_t lo_code(pair_idx_t p);
		case (p)
			`SM83_PAIR_BC: return `SM83_REG_C;
			`SM83_PAIR_DE: return `SM83_REG_E;
			default:       return `SM83_REG_L;
		endcase
	endfunction

	function automatic addr_t expect_addr(uop_t u);
		case (u.asrc)
			`SM83_ASRC_PAIR: begin
				if (u.pair == `SM83_PAIR_SP) begin
					return m_sp;
				end
				return {m_regs[hi_code(u.pair)], m_regs[lo_code(u.pair)]};
			end
			`SM83_ASRC_WZ: return {m_w, m_z};
			default:       return m_pc;
		endcase
	endfunction

	function automatic byte_t expect_data(uop_t u);
		case (u.out_src)
			`SM83_OUT_PCL: return m_pc[7:0];
			`SM83_OUT_PCH: return m_pc[15:8];
			`SM83_OUT_SPL: return m_sp[7:0];
			`SM83_OUT_SPH: return m_sp[15:8];
			default:       return m_regs[u.src_idx];   // Code 6 reads as zero
		endcase
	endfunction

	task automatic reset_model();
		for (int i = 0; i < 8; i++) begin
			m_regs[i] = '0;
		end
		m_ir = '0;
		m_w  = '0;
		m_z  = '0;
		m_pc = '0;
		m_sp = '0;
	endtask

	task automatic drive_random();
		logic [31:0] r;
		uop_t        u;
		r = $random(seed);
		u.ir_ld   = r[0];
		u.dst_we  = r[1];
		u.dst_idx = r[4:2];
		u.src_idx = r[7:5];
		u.z_we    = r[8];
		u.w_we    = r[9];
		u.pair    = r[11:10];
		u.idu_wb  = r[13:12];
		u.jump    = (r[16:14] == 3'd0);   // About one in eight
		r = $random(seed);
		u.dst_src = 2'(r[7:0] % 3);
		u.asrc    = 2'(r[15:8] % 3);
		u.idu_op  = 2'(r[23:16] % 3);
		u.out_src = 3'(r[31:24] % 5);
		uop = u;
		r = $random(seed);
		data_in  = r[7:0];
		alu_res  = r[15:8];
		sync_res = (r[31:26] == 6'd0);   // About one in 64
	endtask

	task automatic check_outputs();
		addr_t exp_addr;
		byte_t exp_data;
		exp_addr = expect_addr(uop);
		exp_data = expect_data(uop);
		assert (addr === exp_addr) else begin
			addr_errs++;
			$display("error at %0t ns: addr %h, expected %h", $time, addr, exp_addr);
		end
		assert (data_out === exp_data) else begin
			data_errs++;
			$display("error at %0t ns: data_out %h, expected %h", $time, data_out, exp_data);
		end
		assert (a_out === m_regs[`SM83_REG_A]) else begin
			a_errs++;
			$display("error at %0t ns: a_out %h, expected %h", $time, a_out,
				m_regs[`SM83_REG_A]);
		end
		assert (ir === m_ir) else begin
			ir_errs++;
			$display("error at %0t ns: ir %h, expected %h", $time, ir, m_ir);
		end
	endtask

	// Applies the current micro-op as the next edge will
	task automatic update_model();
		addr_t a;
		addr_t res;
		byte_t wr;
		a = expect_addr(uop);
		case (uop.idu_op)
			`SM83_IDU_INC: res = a + 16'd1;
			`SM83_IDU_DEC: res = a - 16'd1;
			default:       res = a;
		endcase
		case (uop.dst_src)
			`SM83_DSRC_DATA: wr = data_in;
			`SM83_DSRC_ALU:  wr = alu_res;
			default:         wr = m_regs[uop.src_idx];
		endcase
		if (sync_res) begin
			m_pc = '0;
		end else if (uop.jump) begin
			m_pc = {m_w, m_z};   // Old WZ, before this cycle's loads
		end else if (uop.idu_wb == `SM83_WB_PC) begin
			m_pc = res;
		end
		if ((uop.idu_wb == `SM83_WB_SP) ||
			((uop.idu_wb == `SM83_WB_PAIR) && (uop.pair == `SM83_PAIR_SP))) begin
			m_sp = res;
		end
		if ((uop.idu_wb == `SM83_WB_PAIR) && (uop.pair != `SM83_PAIR_SP)) begin
			m_regs[hi_code(uop.pair)] = res[15:8];
			m_regs[lo_code(uop.pair)] = res[7:0];
		end
		if (uop.dst_we && (uop.dst_idx != `SM83_REG_HLM)) begin
			m_regs[uop.dst_idx] = wr;   // Overrides a pair write
		end
		if (uop.ir_ld) begin
			m_ir = data_in;
		end
		if (uop.z_we) begin
			m_z = data_in;
		end
		if (uop.w_we) begin
			m_w = data_in;
		end
	endtask

	initial begin
		uop       = '0;
		data_in   = '0;
		alu_res   = '0;
		sync_res  = 1'b0;
		arst_n    = 1'b0;
		addr_errs = 0;
		data_errs = 0;
		a_errs    = 0;
		ir_errs   = 0;
		chk_errs  = 0;
		reset_model();
		repeat (5) @(posedge clk);
		#1;
		arst_n = 1'b1;
		check_outputs();   // Everything reads zero out of reset
		repeat (NUM_UOPS) begin
			@(posedge clk);
			#1;
			drive_random();
			#2;
			check_outputs();
			update_model();
		end
		@(posedge clk);
		#1;
		uop      = '0;
		sync_res = 1'b0;
		#2;
		check_outputs();
		chk_errs = sm83_regs_top_inst.sm83_regs_chk_inst.assert_errs;
		$display("Error counts: addr %0d, data_out %0d, a_out %0d, ir %0d, assertions %0d",
			addr_errs, data_errs, a_errs, ir_errs, chk_errs);
		if ((addr_errs + data_errs + a_errs + ir_errs + chk_errs) == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	initial begin
		#((NUM_UOPS + 20) * CLK_PERIOD + 100);
		$display("Watchdog: the run timed out before all micro-ops were applied");
		$display("Regression failed");
		$finish;
	end

endmodule
